//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP       = rv_core_tb
FILELIST  = build.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "test passed" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
verilog/core_pkg.sv
verilog/rv_isa_pkg.sv
verilog/fetch_unit.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/execute_stage.sv
verilog/rv_core.sv
tests/rv_core_tb.sv

//--- tests/core_tests.dat
# P addr data: write instruction word data at word address addr, both hex
# G: run until halt; R reg value: expected register value after that run, hex
# program 1: alu operations, forwarding one and two behind, write to x0
P 00 00500093  # addi x1, x0, 5
P 01 00708113  # addi x2, x1, 7
P 02 002081b3  # add  x3, x1, x2
P 03 40208233  # sub  x4, x1, x2
P 04 fff24293  # xori x5, x4, -1
P 05 00f1f313  # andi x6, x3, 15
P 06 0300e393  # ori  x7, x1, 0x30
P 07 ffa22413  # slti x8, x4, -6
P 08 001124b3  # slt  x9, x2, x1
P 09 00717533  # and  x10, x2, x7
P 0a 0020e5b3  # or   x11, x1, x2
P 0b 0020c633  # xor  x12, x1, x2
P 0c 123456b7  # lui  x13, 0x12345
P 0d 00108013  # addi x0, x1, 1
P 0e 00100073  # ebreak
G
R 00 00000000  R 01 00000005  R 02 0000000c  R 03 00000011
R 04 fffffff9  R 05 00000006  R 06 00000001  R 07 00000035
R 08 00000001  R 09 00000000  R 0a 00000004  R 0b 0000000d
R 0c 00000009  R 0d 12345000
# program 2: taken and not-taken branches, jal, older registers kept
P 00 00300713  # addi x14, x0, 3
P 01 00300793  # addi x15, x0, 3
P 02 00f70663  # beq  x14, x15, +12 (taken)
P 03 00100813  # addi x16, x0, 1 (skipped)
P 04 00100893  # addi x17, x0, 1 (skipped)
P 05 00f71463  # bne  x14, x15, +8 (not taken)
P 06 05500913  # addi x18, x0, 0x55
P 07 01271663  # bne  x14, x18, +12 (taken)
P 08 00100993  # addi x19, x0, 1 (skipped)
P 09 00100a13  # addi x20, x0, 1 (skipped)
P 0a 00c000ef  # jal  x1, +12
P 0b 00100a93  # addi x21, x0, 1 (skipped)
P 0c 00100b13  # addi x22, x0, 1 (skipped)
P 0d 0080006f  # jal  x0, +8
P 0e 00100b93  # addi x23, x0, 1 (skipped)
P 0f 01208c33  # add  x24, x1, x18
P 10 00100073  # ebreak
G
R 00 00000000  R 01 0000002c  R 02 0000000c  R 03 00000011
R 0d 12345000  R 0e 00000003  R 0f 00000003  R 10 00000000
R 11 00000000  R 12 00000055  R 13 00000000  R 14 00000000
R 15 00000000  R 16 00000000  R 17 00000000  R 18 00000081

//--- tests/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb
    import core_pkg::*;
();

    localparam time DRIVE_DELAY = 1ns;
    localparam string TEST_FILE = "tests/core_tests.dat";

    logic clk;
    logic rst_n;
    logic run;
    logic prog_we;
    imem_addr_t prog_addr;
    word_t prog_data;
    reg_idx_t reg_sel;
    logic busy;
    word_t reg_data;

    int cycle_count = 0;
    int words_read = 0;
    int runs_done = 0;

    rv_core DUT (
        .clk(clk),
        .rst_n(rst_n),
        .run(run),
        .prog_we(prog_we),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .reg_sel(reg_sel),
        .busy(busy),
        .reg_data(reg_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // inputs change just after the rising edge
    task automatic step_clock();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic load_word(imem_addr_t addr, word_t data);
        prog_we = 1'b1;
        prog_addr = addr;
        prog_data = data;
        step_clock();
        prog_we = 1'b0;
        words_read++;
    endtask

    // busy rises one cycle after run, falls some time after the halt
    task automatic run_program();
        run = 1'b1;
        step_clock();
        run = 1'b0;
        check_bit("busy", busy, 1'b1);
        while (busy) begin
            step_clock();
        end
        runs_done++;
    endtask

    task automatic expect_register(reg_idx_t idx, word_t exp);
        reg_sel = idx;
        step_clock();
        check_word($sformatf("reg_data[x%0d]", idx), reg_data, exp);
    endtask

    // limit grows with the number of program words loaded
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > 20 * words_read + 100) begin
            abort_run($sformatf("timeout: the core did not halt within %0d cycles",
                                cycle_count));
        end
    end

    initial begin
        int fd;
        int code;
        logic [7:0] kind;
        imem_addr_t addr;
        word_t data;
        reg_idx_t idx;
        logic [8*160-1:0] rest;

        rst_n = 1'b0;
        run = 1'b0;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        reg_sel = '0;

        repeat (2) step_clock();
        rst_n = 1'b1;
        step_clock();
        check_bit("busy", busy, 1'b0);

        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            abort_run("could not open the data file tests/core_tests.dat");
        end

        // one record kind letter, then its fields
        code = $fscanf(fd, " %c", kind);
        while (code == 1) begin
            case (kind)
                "#": begin
                    code = $fgets(rest, fd);
                end
                "P": begin
                    code = $fscanf(fd, " %h %h", addr, data);
                    if (code != 2) begin
                        abort_run("malformed program record in the data file");
                    end
                    load_word(addr, data);
                end
                "R": begin
                    code = $fscanf(fd, " %h %h", idx, data);
                    if (code != 2) begin
                        abort_run("malformed register record in the data file");
                    end
                    expect_register(idx, data);
                end
                "G": begin
                    run_program();
                end
                default: begin
                    abort_run($sformatf("unknown record kind %c in the data file", kind));
                end
            endcase
            code = $fscanf(fd, " %c", kind);
        end
        $fclose(fd);

        if (runs_done == 0) begin
            $display("no program was run from the data file");
            $display("test failed");
            $fatal(1);
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule : rv_core_tb

//--- verilog/core_pkg.sv
package core_pkg;

    // data path and register index widths
    localparam int XLEN = 32;
    localparam int REG_AW = 5;

    // on-chip instruction memory, one word per entry
    localparam int IMEM_DEPTH = 64;
    localparam int IMEM_AW = 6;

    // byte distance between consecutive instructions
    localparam int PC_STEP = 4;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [REG_AW-1:0] reg_idx_t;
    typedef logic [IMEM_AW-1:0] imem_addr_t;

    // run/busy state of the core
    typedef enum logic {
        MODE_IDLE,
        MODE_RUNNING
    } core_mode_t;

endpackage : core_pkg

//--- verilog/decoder.sv
`timescale 1ns/10ps

module decoder
    import core_pkg::*;
    import rv_isa_pkg::*;
(
    input  word_t    instr,
    output op_t      op,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd,
    output word_t    imm,
    output logic     use_imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t imm_i;
    word_t imm_u;
    word_t imm_b;
    word_t imm_j;
    logic writes_rd;

    // funct3 to alu operation, shared by op and op-imm
    function automatic op_t alu_op(logic [2:0] f3);
        case (f3)
            F3_ADD:  return OP_ADD;
            F3_SLT:  return OP_SLT;
            F3_XOR:  return OP_XOR;
            F3_OR:   return OP_OR;
            F3_AND:  return OP_AND;
            default: return OP_NOP;
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];

    // sign-extended immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        op = OP_NOP;
        imm = '0;
        use_imm = 1'b0;
        case (opcode)
            OPC_OP_IMM: begin
                op = alu_op(funct3);
                imm = imm_i;
                use_imm = 1'b1;
            end
            OPC_OP: begin
                if (funct7 == F7_SUB && funct3 == F3_ADD) begin
                    op = OP_SUB;
                end else if (funct7 == '0) begin
                    op = alu_op(funct3);
                end
            end
            OPC_LUI: begin
                op = OP_LUI;
                imm = imm_u;
                use_imm = 1'b1;
            end
            OPC_BRANCH: begin
                imm = imm_b;
                if (funct3 == F3_BEQ) begin
                    op = OP_BEQ;
                end else if (funct3 == F3_BNE) begin
                    op = OP_BNE;
                end
            end
            OPC_JAL: begin
                op = OP_JAL;
                imm = imm_j;
            end
            OPC_SYSTEM: begin
                if (funct3 == '0 && instr[31:20] == F12_EBREAK) begin
                    op = OP_HALT;
                end
            end
            default: op = OP_NOP;
        endcase
    end

    // branches, halt and nops never write, so their rd reads as x0
    assign writes_rd = !(op inside {OP_NOP, OP_BEQ, OP_BNE, OP_HALT});
    assign rd = writes_rd ? instr[11:7] : '0;

endmodule : decoder

//--- verilog/execute_stage.sv
`timescale 1ns/10ps

module execute_stage
    import core_pkg::*;
    import rv_isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     e_valid,
    input  op_t      e_op,
    input  reg_idx_t e_rd,
    input  reg_idx_t e_rs1,
    input  reg_idx_t e_rs2,
    input  word_t    e_rs1_data,
    input  word_t    e_rs2_data,
    input  word_t    e_imm,
    input  logic     e_use_imm,
    input  word_t    e_pc,
    output logic     redirect,
    output word_t    redirect_pc,
    output logic     halt,
    output logic     wb_en,
    output reg_idx_t wb_rd,
    output word_t    wb_data
);

    word_t op_a;
    word_t op_rs2;
    word_t op_b;
    word_t result;
    logic taken;

    // the instruction one ahead sits in the writeback register
    function automatic word_t forward(reg_idx_t idx, word_t rf_val);
        if (wb_en && wb_rd != '0 && wb_rd == idx) begin
            return wb_data;
        end
        return rf_val;
    endfunction

    assign op_a = forward(e_rs1, e_rs1_data);
    assign op_rs2 = forward(e_rs2, e_rs2_data);
    assign op_b = e_use_imm ? e_imm : op_rs2;

    always_comb begin
        case (e_op)
            OP_ADD:  result = op_a + op_b;
            OP_SUB:  result = op_a - op_b;
            OP_AND:  result = op_a & op_b;
            OP_OR:   result = op_a | op_b;
            OP_XOR:  result = op_a ^ op_b;
            OP_SLT:  result = word_t'($signed(op_a) < $signed(op_b));
            OP_LUI:  result = e_imm;
            // link value
            OP_JAL:  result = e_pc + word_t'(PC_STEP);
            default: result = '0;
        endcase
    end

    // branch compare uses rs2, never the immediate
    always_comb begin
        case (e_op)
            OP_BEQ:  taken = (op_a == op_rs2);
            OP_BNE:  taken = (op_a != op_rs2);
            OP_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect = e_valid && taken;
    assign redirect_pc = e_pc + e_imm;
    assign halt = e_valid && e_op == OP_HALT;

    // writeback register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= e_valid && e_rd != '0;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd <= e_rd;
        wb_data <= result;
    end

    // no trap exists for a misaligned target
    a_redirect_aligned : assert property (
        @(posedge clk) disable iff (!rst_n) redirect |-> redirect_pc[1:0] == 2'b00
    );

endmodule : execute_stage

//--- verilog/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  logic       flush,
    input  logic       redirect,
    input  word_t      redirect_pc,
    input  logic       prog_we,
    input  imem_addr_t prog_addr,
    input  word_t      prog_data,
    output logic       f_valid,
    output word_t      f_pc,
    output word_t      f_instr
);

    word_t imem [IMEM_DEPTH];
    word_t pc;
    imem_addr_t pc_idx;

    // byte address to word index
    assign pc_idx = pc[IMEM_AW+1:2];

    // program load port, only used while idle
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (start) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!flush) begin
            pc <= pc + word_t'(PC_STEP);
        end
    end

    // fetch register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            f_valid <= 1'b0;
        end else begin
            f_valid <= !(flush || redirect);
        end
    end

    always_ff @(posedge clk) begin
        f_pc <= pc;
        f_instr <= imem[pc_idx];
    end

    // memory must only be written while the pipeline is held
    a_load_while_flushed : assert property (
        @(posedge clk) disable iff (!rst_n) prog_we |-> flush
    );

endmodule : fetch_unit

//--- verilog/regfile.sv
`timescale 1ns/10ps

module regfile
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t reg_sel,
    input  logic     wb_en,
    input  reg_idx_t wb_rd,
    input  word_t    wb_data,
    output word_t    rs1_data,
    output word_t    rs2_data,
    output word_t    reg_data
);

    word_t regs [2**REG_AW];

    // x0 reads zero, a same-cycle write is passed through
    function automatic word_t read_port(reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_en && wb_rd == idx) begin
            return wb_data;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign rs1_data = read_port(rs1);
    assign rs2_data = read_port(rs2);
    // debug read
    assign reg_data = read_port(reg_sel);

    // decoder zeroes rd for x0 targets, execute only enables nonzero rd
    a_no_x0_write : assert property (
        @(posedge clk) disable iff (!rst_n) wb_en |-> wb_rd != '0
    );

endmodule : regfile

//--- verilog/rv_core.sv
`timescale 1ns/10ps

module rv_core
    import core_pkg::*;
    import rv_isa_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       run,
    input  logic       prog_we,
    input  imem_addr_t prog_addr,
    input  word_t      prog_data,
    input  reg_idx_t   reg_sel,
    output logic       busy,
    output word_t      reg_data
);

    core_mode_t mode;
    logic start;
    logic flush;
    logic halt;
    logic redirect;
    word_t redirect_pc;

    logic f_valid;
    word_t f_pc;
    word_t f_instr;

    op_t dec_op;
    reg_idx_t dec_rs1;
    reg_idx_t dec_rs2;
    reg_idx_t dec_rd;
    word_t dec_imm;
    logic dec_use_imm;
    word_t rs1_data;
    word_t rs2_data;

    // decode-to-execute register
    logic e_valid;
    op_t e_op;
    reg_idx_t e_rd;
    reg_idx_t e_rs1;
    reg_idx_t e_rs2;
    word_t e_rs1_data;
    word_t e_rs2_data;
    word_t e_imm;
    logic e_use_imm;
    word_t e_pc;

    logic wb_en;
    reg_idx_t wb_rd;
    word_t wb_data;

    // run control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mode <= MODE_IDLE;
        end else if (mode == MODE_IDLE && run) begin
            mode <= MODE_RUNNING;
        end else if (halt) begin
            mode <= MODE_IDLE;
        end
    end

    assign busy = (mode == MODE_RUNNING);
    assign start = (mode == MODE_IDLE) && run;
    // held while idle, younger instructions dropped on halt
    assign flush = (mode == MODE_IDLE) || halt;

    fetch_unit u_fetch (
        .clk(clk),
        .rst_n(rst_n),
        .start(start),
        .flush(flush),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .prog_we(prog_we),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .f_valid(f_valid),
        .f_pc(f_pc),
        .f_instr(f_instr)
    );

    decoder u_decoder (
        .instr(f_instr),
        .op(dec_op),
        .rs1(dec_rs1),
        .rs2(dec_rs2),
        .rd(dec_rd),
        .imm(dec_imm),
        .use_imm(dec_use_imm)
    );

    regfile u_regfile (
        .clk(clk),
        .rst_n(rst_n),
        .rs1(dec_rs1),
        .rs2(dec_rs2),
        .reg_sel(reg_sel),
        .wb_en(wb_en),
        .wb_rd(wb_rd),
        .wb_data(wb_data),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .reg_data(reg_data)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            e_valid <= 1'b0;
        end else begin
            e_valid <= f_valid && !(flush || redirect);
        end
    end

    always_ff @(posedge clk) begin
        e_op <= dec_op;
        e_rd <= dec_rd;
        e_rs1 <= dec_rs1;
        e_rs2 <= dec_rs2;
        e_rs1_data <= rs1_data;
        e_rs2_data <= rs2_data;
        e_imm <= dec_imm;
        e_use_imm <= dec_use_imm;
        e_pc <= f_pc;
    end

    execute_stage u_execute (
        .clk(clk),
        .rst_n(rst_n),
        .e_valid(e_valid),
        .e_op(e_op),
        .e_rd(e_rd),
        .e_rs1(e_rs1),
        .e_rs2(e_rs2),
        .e_rs1_data(e_rs1_data),
        .e_rs2_data(e_rs2_data),
        .e_imm(e_imm),
        .e_use_imm(e_use_imm),
        .e_pc(e_pc),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .halt(halt),
        .wb_en(wb_en),
        .wb_rd(wb_rd),
        .wb_data(wb_data)
    );

    // the pipeline is flushed while idle, so no halt can reach execute
    a_no_halt_when_idle : assert property (
        @(posedge clk) disable iff (!rst_n) halt |-> mode == MODE_RUNNING
    );

endmodule : rv_core

//--- verilog/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes, instr[6:0]
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct3, instr[14:12]
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // funct7, instr[31:25]
    localparam logic [6:0] F7_SUB = 7'b0100000;

    // funct12 of the system opcode that selects ebreak
    localparam logic [11:0] F12_EBREAK = 12'h001;

    // decoded operations
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_LUI,
        OP_BEQ,
        OP_BNE,
        OP_JAL,
        OP_HALT
    } op_t;

endpackage : rv_isa_pkg
